// ==== hw/vcr_input_port.sv ====
// Router input port
// Two VC flit FIFOs selected by the header vc_id, XY route of each
// VC head, and a one-cycle credit pulse upstream for every pop

`timescale 1ns/1ps
`default_nettype none

module vcr_input_port import vcr_pkg::*; #(
  parameter int unsigned XPos    = 0,
  parameter int unsigned YPos    = 0,
  // Slice of the crossbar bundle owned by this port
  parameter int unsigned PortIdx = 0
) (
  input  logic                               clk_i,
  input  logic                               reset_i,
  input  logic                               valid_i,
  input  flit_t                              flit_i,
  vcr_xbar_if.buffer                         xbar,
  output logic [NumVC-1:0][NumPorts-1:0]     route_req_o,
  output logic [NumVC-1:0]                   vc_valid_o,
  input  logic [NumVC-1:0]                   pop_i,
  output logic [NumVC-1:0]                   credit_o
);

  flit_t                          mem_q [NumVC][BufDepth];
  logic  [NumVC-1:0][PtrWidth-1:0] wr_ptr_q;
  logic  [NumVC-1:0][PtrWidth-1:0] rd_ptr_q;
  logic  [NumVC-1:0][CntWidth-1:0] count_q;
  logic  [NumVC-1:0]               wr_en;
  logic  [NumVC-1:0]               credit_q;
  flit_t [NumVC-1:0]               head;
  hdr_t                            sel_hdr;

  always_comb begin
    for (int v = 0; v < NumVC; v++) begin
      wr_en[v]      = valid_i && (flit_i.hdr.vc_id == VcIdxWidth'(v));
      head[v]       = mem_q[v][rd_ptr_q[v]];
      vc_valid_o[v] = (count_q[v] != '0);
    end
  end

  // Flit storage
  always_ff @(posedge clk_i) begin
    for (int v = 0; v < NumVC; v++) begin
      if (wr_en[v]) begin
        mem_q[v][wr_ptr_q[v]] <= flit_i;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      credit_q <= '0;
    end else begin
      for (int v = 0; v < NumVC; v++) begin
        if (wr_en[v]) begin
          wr_ptr_q[v] <= (wr_ptr_q[v] == PtrWidth'(BufDepth - 1)) ? '0 : wr_ptr_q[v] + 1'b1;
        end
        if (pop_i[v]) begin
          rd_ptr_q[v] <= (rd_ptr_q[v] == PtrWidth'(BufDepth - 1)) ? '0 : rd_ptr_q[v] + 1'b1;
        end
        count_q[v] <= count_q[v] + CntWidth'(wr_en[v]) - CntWidth'(pop_i[v]);
      end
      // Each pop frees one slot upstream
      credit_q <= pop_i;
    end
  end

  assign credit_o = credit_q;

  // XY routing, X first. Larger y lies to the North
  always_comb begin
    for (int v = 0; v < NumVC; v++) begin
      route_req_o[v] = '0;
      if (head[v].hdr.dst_x > CoordWidth'(XPos)) begin
        route_req_o[v][East] = 1'b1;
      end else if (head[v].hdr.dst_x < CoordWidth'(XPos)) begin
        route_req_o[v][West] = 1'b1;
      end else if (head[v].hdr.dst_y > CoordWidth'(YPos)) begin
        route_req_o[v][North] = 1'b1;
      end else if (head[v].hdr.dst_y < CoordWidth'(YPos)) begin
        route_req_o[v][South] = 1'b1;
      end else begin
        route_req_o[v][Local] = 1'b1;
      end
    end
  end

  // Header of the VC chosen by the allocator
  always_comb begin
    sel_hdr = '0;
    for (int v = 0; v < NumVC; v++) begin
      if (xbar.read_vc_oh[PortIdx][v]) begin
        sel_hdr = head[v].hdr;
      end
    end
  end

  assign xbar.vc_head[PortIdx]  = head;
  assign xbar.hdr_head[PortIdx] = sel_hdr;

endmodule

`default_nettype wire

// ==== hw/vcr_pkg.sv ====
// Virtual-channel mesh router shared definitions
// Port indices, buffer sizes, coordinate widths and the flit format

`default_nettype none

package vcr_pkg;

  // Router ports
  localparam int unsigned NumPorts = 5;

  localparam int unsigned North = 0;
  localparam int unsigned East  = 1;
  localparam int unsigned South = 2;
  localparam int unsigned West  = 3;
  localparam int unsigned Local = 4;

  // Virtual channels and their buffers
  localparam int unsigned NumVC    = 2;
  localparam int unsigned BufDepth = 4;

  // Derived index and counter widths
  localparam int unsigned VcIdxWidth   = $clog2(NumVC);
  localparam int unsigned PortIdxWidth = $clog2(NumPorts);
  localparam int unsigned PtrWidth     = $clog2(BufDepth);
  localparam int unsigned CntWidth     = $clog2(BufDepth + 1);

  // Flit fields
  localparam int unsigned CoordWidth   = 3;
  localparam int unsigned SeqWidth     = 8;
  localparam int unsigned PayloadWidth = 32;

  typedef struct packed {
    logic [CoordWidth-1:0] dst_x;
    logic [CoordWidth-1:0] dst_y;
    logic [CoordWidth-1:0] src_x;
    logic [CoordWidth-1:0] src_y;
    logic                  vc_id;
    logic [SeqWidth-1:0]   seq;
  } hdr_t;

  // Payload sits in the low bits of the flit
  typedef struct packed {
    hdr_t                    hdr;
    logic [PayloadWidth-1:0] payload;
  } flit_t;

endpackage

`default_nettype wire

// ==== hw/vcr_router.sv ====
// Five-port virtual-channel mesh router
// Input buffers, separable switch allocator and XY crossbar

`timescale 1ns/1ps
`default_nettype none

module vcr_router import vcr_pkg::*; #(
  parameter int unsigned XPos = 0,
  parameter int unsigned YPos = 0
) (
  input  logic                            clk_i,
  input  logic                            reset_i,
  input  logic  [NumPorts-1:0]            valid_i,
  input  flit_t [NumPorts-1:0]            flit_i,
  output logic  [NumPorts-1:0]            valid_o,
  output flit_t [NumPorts-1:0]            flit_o,
  output logic  [NumPorts-1:0][NumVC-1:0] credit_o
);

  logic [NumPorts-1:0][NumVC-1:0][NumPorts-1:0] route_req;
  logic [NumPorts-1:0][NumVC-1:0]               vc_valid;
  logic [NumPorts-1:0][NumVC-1:0]               pop;

  vcr_xbar_if xbar_bus ();

  for (genvar p = 0; p < NumPorts; p++) begin : gen_in_port
    vcr_input_port #(
      .XPos    (XPos),
      .YPos    (YPos),
      .PortIdx (p)
    ) u_input_port (
      .clk_i       (clk_i),
      .reset_i     (reset_i),
      .valid_i     (valid_i[p]),
      .flit_i      (flit_i[p]),
      .xbar        (xbar_bus.buffer),
      .route_req_o (route_req[p]),
      .vc_valid_o  (vc_valid[p]),
      .pop_i       (pop[p]),
      .credit_o    (credit_o[p])
    );
  end

  vcr_switch_alloc u_switch_alloc (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .xbar        (xbar_bus.alloc),
    .route_req_i (route_req),
    .vc_valid_i  (vc_valid),
    .pop_o       (pop)
  );

  vcr_switch u_switch (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .xbar    (xbar_bus.xbar),
    .valid_o (valid_o),
    .flit_o  (flit_o)
  );

endmodule

`default_nettype wire

// ==== hw/vcr_switch.sv ====
// Router crossbar for XY routing
// Only XY-legal input to output paths exist. Flit and valid are registered

`timescale 1ns/1ps
`default_nettype none

module vcr_switch import vcr_pkg::*; (
  input  logic                clk_i,
  input  logic                reset_i,
  vcr_xbar_if.xbar            xbar,
  output logic [NumPorts-1:0] valid_o,
  output flit_t [NumPorts-1:0] flit_o
);

  logic  [NumPorts-1:0][PayloadWidth-1:0] data_head;
  flit_t [NumPorts-1:0]                   flit_d;
  logic  [NumPorts-1:0]                   valid_d;
  flit_t [NumPorts-1:0]                   flit_q;
  logic  [NumPorts-1:0]                   valid_q;

  // No U-turns apart from Local ejection, and N/S traffic never turns back into X
  function automatic logic xy_legal(input int unsigned in_port, input int unsigned out_port);
    return !((in_port == out_port && in_port != Local) ||
             ((out_port == East || out_port == West) &&
              (in_port == North || in_port == South)));
  endfunction

  // Payload of the selected VC per input port
  always_comb begin
    data_head = '0;
    for (int p = 0; p < NumPorts; p++) begin
      for (int v = 0; v < NumVC; v++) begin
        if (xbar.read_vc_oh[p][v]) begin
          data_head[p] = xbar.vc_head[p][v].payload;
        end
      end
    end
  end

  always_comb begin
    flit_d  = '0;
    valid_d = '0;
    for (int o = 0; o < NumPorts; o++) begin
      for (int p = 0; p < NumPorts; p++) begin
        if (xy_legal(p, o) && xbar.inport_oh_per_output[o][p]) begin
          valid_d[o]            = 1'b1;
          flit_d[o].payload     = data_head[p];
          flit_d[o].hdr.dst_x   = xbar.hdr_head[p].dst_x;
          flit_d[o].hdr.dst_y   = xbar.hdr_head[p].dst_y;
          flit_d[o].hdr.src_x   = xbar.hdr_head[p].src_x;
          flit_d[o].hdr.src_y   = xbar.hdr_head[p].src_y;
          flit_d[o].hdr.vc_id   = xbar.hdr_head[p].vc_id;
          flit_d[o].hdr.seq     = xbar.hdr_head[p].seq;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_q <= '0;
    end else begin
      valid_q <= valid_d;
    end
  end

  always_ff @(posedge clk_i) begin
    flit_q <= flit_d;
  end

  assign valid_o = valid_q;
  assign flit_o  = flit_q;

endmodule

`default_nettype wire

// ==== hw/vcr_switch_alloc.sv ====
// Separable switch allocator
// Stage one picks a VC per input port, stage two picks an input per
// output, both round-robin. Pointers move only when a grant is given

`timescale 1ns/1ps
`default_nettype none

module vcr_switch_alloc import vcr_pkg::*; (
  input  logic                                         clk_i,
  input  logic                                         reset_i,
  vcr_xbar_if.alloc                                    xbar,
  input  logic [NumPorts-1:0][NumVC-1:0][NumPorts-1:0] route_req_i,
  input  logic [NumPorts-1:0][NumVC-1:0]               vc_valid_i,
  output logic [NumPorts-1:0][NumVC-1:0]               pop_o
);

  logic [NumPorts-1:0][VcIdxWidth-1:0]   vc_ptr_q;
  logic [NumPorts-1:0][PortIdxWidth-1:0] out_ptr_q;
  logic [NumPorts-1:0][NumVC-1:0]        vc_sel;
  // Both indexed [output][input]
  logic [NumPorts-1:0][NumPorts-1:0]     out_req;
  logic [NumPorts-1:0][NumPorts-1:0]     out_gnt;
  logic [NumPorts-1:0]                   in_granted;

  // First requester at or after ptr among the low n bits
  function automatic logic [NumPorts-1:0] rr_pick(
    input logic [NumPorts-1:0] req,
    input int unsigned         ptr,
    input int unsigned         n
  );
    logic [NumPorts-1:0] gnt;
    logic                found;
    int unsigned         idx;
    gnt   = '0;
    found = 1'b0;
    for (int unsigned i = 0; i < NumPorts; i++) begin
      idx = (ptr + i) % n;
      if (i < n && !found && req[idx]) begin
        gnt[idx] = 1'b1;
        found    = 1'b1;
      end
    end
    return gnt;
  endfunction

  // Stage one, VC choice per input port
  always_comb begin : vc_stage
    logic [NumPorts-1:0] pick;
    pick   = '0;
    vc_sel = '0;
    for (int p = 0; p < NumPorts; p++) begin
      pick      = rr_pick(NumPorts'(vc_valid_i[p]), int'(vc_ptr_q[p]), NumVC);
      vc_sel[p] = pick[NumVC-1:0];
    end
  end

  // Stage two, input choice per output port
  always_comb begin
    out_req = '0;
    for (int o = 0; o < NumPorts; o++) begin
      for (int p = 0; p < NumPorts; p++) begin
        for (int v = 0; v < NumVC; v++) begin
          out_req[o][p] = out_req[o][p] | (vc_sel[p][v] & route_req_i[p][v][o]);
        end
      end
      out_gnt[o] = rr_pick(out_req[o], int'(out_ptr_q[o]), NumPorts);
    end
  end

  // An input requests one output at most, so one grant per input
  always_comb begin
    in_granted = '0;
    for (int p = 0; p < NumPorts; p++) begin
      for (int o = 0; o < NumPorts; o++) begin
        in_granted[p] = in_granted[p] | out_gnt[o][p];
      end
      pop_o[p] = vc_sel[p] & {NumVC{in_granted[p]}};
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      vc_ptr_q  <= '0;
      out_ptr_q <= '0;
    end else begin
      for (int p = 0; p < NumPorts; p++) begin
        for (int v = 0; v < NumVC; v++) begin
          if (pop_o[p][v]) begin
            vc_ptr_q[p] <= VcIdxWidth'((v + 1) % NumVC);
          end
        end
      end
      for (int o = 0; o < NumPorts; o++) begin
        for (int p = 0; p < NumPorts; p++) begin
          if (out_gnt[o][p]) begin
            out_ptr_q[o] <= PortIdxWidth'((p + 1) % NumPorts);
          end
        end
      end
    end
  end

  assign xbar.read_vc_oh           = vc_sel;
  assign xbar.inport_oh_per_output = out_gnt;

endmodule

`default_nettype wire

// ==== hw/vcr_xbar_if.sv ====
// Crossbar bundle between input buffers, switch allocator and switch
// Carries VC heads, selected headers and the allocator's one-hot selections

`timescale 1ns/1ps
`default_nettype none

interface vcr_xbar_if import vcr_pkg::*; ();

  // Head flit of every VC, indexed [port][vc]
  flit_t [NumPorts-1:0][NumVC-1:0]    vc_head;
  // Header of the VC picked by read_vc_oh, per input port
  hdr_t  [NumPorts-1:0]               hdr_head;
  // One-hot VC choice per input port
  logic  [NumPorts-1:0][NumVC-1:0]    read_vc_oh;
  // One-hot input choice, indexed [output][input]
  logic  [NumPorts-1:0][NumPorts-1:0] inport_oh_per_output;

  modport buffer (output vc_head, output hdr_head, input read_vc_oh);

  modport alloc (output read_vc_oh, output inport_oh_per_output);

  modport xbar (
    input vc_head,
    input hdr_head,
    input read_vc_oh,
    input inport_oh_per_output
  );

endinterface

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the router testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f sim.f --top-module tb_vcr_router -o tb_sim > build.log 2>&1 \
  && ./obj_dir/tb_sim > sim.log 2>&1 \
  ; grep -q "TEST PASS" sim.log \
  && echo "Simulation passed" \
  || { echo "Simulation failed, see build.log and sim.log"; exit 1; }

// ==== sim.f ====
hw/vcr_pkg.sv
hw/vcr_xbar_if.sv
hw/vcr_input_port.sv
hw/vcr_switch_alloc.sv
hw/vcr_switch.sv
hw/vcr_router.sv
testbench/tb_vcr_router.sv

// ==== testbench/tb_vcr_router.sv ====
// Testbench for the five-port virtual-channel router at position (2,2)
// Directed tests with a per-output scoreboard, credit tracking and an LFSR

`timescale 1ns/1ps
`default_nettype none

module tb_vcr_router import vcr_pkg::*; ();

  localparam int TimeoutCycles = 6 + 10 + 96 + 30 + 140 + 200;

  logic                            clk_i;
  logic                            reset_i;
  logic  [NumPorts-1:0]            valid_i;
  flit_t [NumPorts-1:0]            flit_i;
  logic  [NumPorts-1:0]            valid_o;
  flit_t [NumPorts-1:0]            flit_o;
  logic  [NumPorts-1:0][NumVC-1:0] credit_o;

  flit_t                exp_q [NumPorts][$];
  int                   credits [NumPorts][NumVC];
  int                   occ [NumPorts][NumVC];
  int                   last_pop [NumPorts];
  logic [NumPorts-1:0]  in_seen;
  logic [NumPorts-1:0]  in_seen_vc;
  logic [NumPorts-1:0]  stage_v;
  flit_t [NumPorts-1:0] stage_f;
  logic [31:0]          lfsr;
  logic [SeqWidth-1:0]  seq_cnt;
  int                   errors;
  int                   checks;
  int                   sent;
  int                   pulses;

  vcr_router #(.XPos(2), .YPos(2)) uut (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .valid_i  (valid_i),
    .flit_i   (flit_i),
    .valid_o  (valid_o),
    .flit_o   (flit_o),
    .credit_o (credit_o)
  );

  always #2 clk_i = ~clk_i;

  // Galois LFSR, one step per bit taken
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r    = {r[30:0], lfsr[0]};
      lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h80200003 : 32'h0);
    end
    return r;
  endfunction

  // No U-turn except Local to Local, and North/South inputs only reach North, South or Local
  function automatic bit legal_path(input int p, input int o);
    if (p == o && p != Local) return 1'b0;
    if ((p == North || p == South) && (o == East || o == West)) return 1'b0;
    return 1'b1;
  endfunction

  // Destination one hop away in the direction of output o
  function automatic flit_t make_flit(input int p, input int o, input int vc);
    flit_t f;
    f.hdr.dst_x   = CoordWidth'((o == East) ? 3 : (o == West) ? 1 : 2);
    f.hdr.dst_y   = CoordWidth'((o == North) ? 3 : (o == South) ? 1 : 2);
    f.hdr.src_x   = CoordWidth'(p);
    f.hdr.src_y   = '0;
    f.hdr.vc_id   = vc[0];
    f.hdr.seq     = seq_cnt;
    f.payload     = take_bits(PayloadWidth);
    seq_cnt       = seq_cnt + 1'b1;
    return f;
  endfunction

  task automatic check_flit(input string name, input flit_t exp, input flit_t obs);
    checks++;
    if (exp !== obs) begin
      $display("ERR %0t %s expected %h observed %h", $time, name, exp, obs);
      errors++;
    end
  endtask

  task automatic check_credit(input string name, input logic [NumVC-1:0] exp,
                              input logic [NumVC-1:0] obs);
    checks++;
    if (exp !== obs) begin
      $display("ERR %0t %s expected %b observed %b", $time, name, exp, obs);
      errors++;
    end
  endtask

  task automatic check_valid(input string name, input logic exp, input logic obs);
    checks++;
    if (exp !== obs) begin
      $display("ERR %0t %s expected %b observed %b", $time, name, exp, obs);
      errors++;
    end
  endtask

  task automatic check_port(input string name, input int exp, input int obs);
    checks++;
    if (exp != obs) begin
      $display("ERR %0t %s expected %0d observed %0d", $time, name, exp, obs);
      errors++;
    end
  endtask

  task automatic stage_flit(input int p, input int o, input int vc);
    stage_v[p] = 1'b1;
    stage_f[p] = make_flit(p, o, vc);
    exp_q[o].push_back(stage_f[p]);
    credits[p][vc]--;
    sent++;
  endtask

  // Applies the staged flits on the next rising edge
  task automatic drive_stage();
    @(posedge clk_i);
    valid_i <= stage_v;
    flit_i  <= stage_f;
    stage_v  = '0;
  endtask

  task automatic wait_drain(input string test);
    int pending;
    for (int c = 0; c < 60; c++) begin
      pending = 0;
      for (int o = 0; o < NumPorts; o++) pending += exp_q[o].size();
      if (pending == 0) return;
      @(negedge clk_i);
    end
    $display("%s: %0d expected flits never arrived", test, pending);
    errors++;
  endtask

  // Scoreboard, credit return and VC alternation
  always @(negedge clk_i) begin
    int idx;
    for (int o = 0; o < NumPorts; o++) begin
      if (!reset_i && valid_o[o]) begin
        idx = -1;
        for (int i = exp_q[o].size() - 1; i >= 0; i--) begin
          if (exp_q[o][i].hdr.src_x == flit_o[o].hdr.src_x &&
              exp_q[o][i].hdr.vc_id == flit_o[o].hdr.vc_id) idx = i;
        end
        if (idx < 0) begin
          $display("Unexpected flit %h on output %0d at %0t", flit_o[o], o, $time);
          errors++;
        end else begin
          check_flit($sformatf("flit_o[%0d]", o), exp_q[o][idx], flit_o[o]);
          exp_q[o].delete(idx);
        end
      end
    end
    for (int p = 0; p < NumPorts; p++) begin
      for (int v = 0; v < NumVC; v++) begin
        if (!reset_i && credit_o[p][v]) begin
          if (last_pop[p] == v && occ[p][1-v] > 0) begin
            $display("Port %0d popped VC %0d twice while the other VC waited", p, v);
            errors++;
          end
          last_pop[p] = v;
          occ[p][v]--;
          credits[p][v]++;
          pulses++;
        end
      end
      // A flit shown here is written on the next edge and may be popped one edge later
      if (in_seen[p]) occ[p][in_seen_vc[p]]++;
      in_seen[p]    = !reset_i && valid_i[p];
      in_seen_vc[p] = flit_i[p].hdr.vc_id;
    end
  end

  task automatic test_reset();
    for (int i = 0; i < 6; i++) begin
      if (i < 5) begin
        @(posedge clk_i);
        if (i == 4) reset_i <= 1'b0;
      end
      @(negedge clk_i);
      for (int p = 0; p < NumPorts; p++) begin
        check_valid($sformatf("valid_o[%0d]", p), 1'b0, valid_o[p]);
        check_credit($sformatf("credit_o[%0d]", p), '0, credit_o[p]);
      end
    end
    $display("reset test done, errors %0d", errors);
  endtask

  // East, West and Local all target Local; grants follow port index order
  task automatic test_contention();
    int order [3];
    int got;
    int first;
    order = '{East, West, Local};
    got   = 0;
    first = 0;
    stage_flit(East, Local, 0);
    stage_flit(West, Local, 0);
    stage_flit(Local, Local, 0);
    drive_stage();
    drive_stage();
    for (int c = 0; c < 12 && got < 3; c++) begin
      @(negedge clk_i);
      if (valid_o[Local]) begin
        if (got == 0) first = c;
        check_port("flit_o[Local].src_x", order[got], int'(flit_o[Local].hdr.src_x));
        // Winners leave on back-to-back cycles
        check_port("Local arrival cycle", first + got, c);
        got++;
      end
    end
    if (got < 3) begin
      $display("contention: only %0d of 3 flits reached Local", got);
      errors++;
    end
    wait_drain("contention");
    $display("contention test done, errors %0d", errors);
  endtask

  task automatic send_one(input int p, input int o, input int vc);
    logic [NumVC-1:0] oh;
    oh = '0;
    oh[vc] = 1'b1;
    stage_flit(p, o, vc);
    drive_stage();
    drive_stage();
    @(negedge clk_i);
    check_valid($sformatf("valid_o[%0d]", o), 1'b0, valid_o[o]);
    check_credit($sformatf("credit_o[%0d]", p), '0, credit_o[p]);
    @(negedge clk_i);
    check_credit($sformatf("credit_o[%0d]", p), oh, credit_o[p]);
    check_valid($sformatf("valid_o[%0d]", o), 1'b1, valid_o[o]);
    @(negedge clk_i);
    check_valid($sformatf("valid_o[%0d]", o), 1'b0, valid_o[o]);
    check_credit($sformatf("credit_o[%0d]", p), '0, credit_o[p]);
  endtask

  task automatic test_single();
    for (int p = 0; p < NumPorts; p++) begin
      for (int o = 0; o < NumPorts; o++) begin
        if (legal_path(p, o)) send_one(p, o, (p + o) % NumVC);
      end
    end
    wait_drain("single");
    $display("single flit test done, errors %0d", errors);
  endtask

  // West competes for East so both Local VCs fill and must alternate
  task automatic test_both_vcs();
    for (int i = 0; i < 8; i++) begin
      stage_flit(Local, (i < 4) ? East : North, (i < 4) ? 0 : 1);
      stage_flit(West, East, i % 2);
      drive_stage();
    end
    drive_stage();
    wait_drain("both VCs");
    $display("both VCs test done, errors %0d", errors);
  endtask

  task automatic test_random();
    int vc;
    int n;
    int pick;
    for (int c = 0; c < 100; c++) begin
      for (int p = 0; p < NumPorts; p++) begin
        if (take_bits(1) == 1) begin
          vc   = int'(take_bits(1));
          pick = int'(take_bits(3)) %
                 ((p == North || p == South) ? 2 : (p == Local) ? 5 : 4);
          n    = 0;
          for (int o = 0; o < NumPorts; o++) begin
            if (legal_path(p, o)) begin
              if (n == pick && credits[p][vc] > 0) stage_flit(p, o, vc);
              n++;
            end
          end
        end
      end
      drive_stage();
    end
    drive_stage();
    wait_drain("random");
    $display("random traffic test done, errors %0d", errors);
  endtask

  initial begin
    #(TimeoutCycles * 4);
    $display("Watchdog expired before the tests completed");
    $display("TEST FAIL");
    $finish;
  end

  initial begin
    clk_i      = 1'b0;
    reset_i    = 1'b1;
    valid_i    = '0;
    flit_i     = '0;
    stage_v    = '0;
    stage_f    = '0;
    in_seen    = '0;
    in_seen_vc = '0;
    lfsr       = 32'hcaefdb44;
    seq_cnt    = '0;
    errors     = 0;
    checks     = 0;
    sent       = 0;
    pulses     = 0;
    for (int p = 0; p < NumPorts; p++) begin
      last_pop[p] = -1;
      for (int v = 0; v < NumVC; v++) begin
        credits[p][v] = BufDepth;
        occ[p][v]     = 0;
      end
    end
    test_reset();
    test_contention();
    test_single();
    test_both_vcs();
    test_random();
    repeat (3) @(negedge clk_i);
    if (pulses != sent) begin
      $display("Credit pulses %0d do not match flits sent %0d", pulses, sent);
      errors++;
    end
    $display("checks %0d, flits %0d, errors %0d", checks, sent, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
